// ==== dual_issue_ctrl.f ====
src/issue_pkg.sv
src/issue_slot_if.sv
src/commit_if.sv
src/pending_write_table.sv
src/free_slot_picker.sv
src/hazard_detect.sv
src/dual_issue_ctrl.sv
sim/tb_dual_issue_ctrl.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the dual-issue control testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing -j 0 \
    --top-module tb_dual_issue_ctrl \
    -f dual_issue_ctrl.f

./obj_dir/Vtb_dual_issue_ctrl | tee sim.log

if grep -qx "SIMULATION PASSED" sim.log; then
    exit 0
fi
echo "run failed, see sim.log"
exit 1

// ==== sim/tb_dual_issue_ctrl.sv ====
/*
 random testbench for the dual-issue control block
 a model table and issue decision predict mask, stall, IDs and lock each cycle
*/
module tb_dual_issue_ctrl;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int NUM_CYCLES     = 2000;
    localparam int TIMEOUT_CYCLES = NUM_CYCLES + NUM_CYCLES / 10;
    localparam int DEPTH          = issue_pkg::TABLE_DEPTH;

    logic clk;
    logic rst_n;
    int   seed;
    int   cycle_cnt;

    // per-slot stimulus, index 0 is the older slot
    logic                 valid [2];
    issue_pkg::reg_addr_t rd [2];
    issue_pkg::reg_addr_t rs1 [2];
    issue_pkg::reg_addr_t rs2 [2];
    logic                 rd_we [2];
    logic                 csr [2];
    logic                 cf [2];
    logic                 ai [2];
    logic                 c_valid [2];
    issue_pkg::commit_id_t c_id [2];

    issue_pkg::issue_mask_t issue_mask;
    logic                   stall;
    issue_pkg::commit_id_t  id0;
    issue_pkg::commit_id_t  id1;
    logic                   lock;

    // model of the pending writes
    issue_pkg::entry_mask_t m_valid;
    issue_pkg::reg_addr_t   m_rd [DEPTH];
    issue_pkg::entry_mask_t nxt_valid;
    issue_pkg::reg_addr_t   nxt_rd [DEPTH];

    issue_pkg::issue_mask_t exp_mask;
    logic                   exp_stall;
    logic                   exp_lock;
    issue_pkg::commit_id_t  exp_id0;
    issue_pkg::commit_id_t  exp_id1;

    int mask_errs;
    int id_errs;
    int bit_errs;

    dual_issue_ctrl uut (
        .clk                    (clk),
        .rst_n                  (rst_n),
        .slot0_valid_i          (valid[0]),
        .slot0_rd_i             (rd[0]),
        .slot0_rs1_i            (rs1[0]),
        .slot0_rs2_i            (rs2[0]),
        .slot0_rd_we_i          (rd_we[0]),
        .slot0_csr_i            (csr[0]),
        .slot0_ctrl_flow_i      (cf[0]),
        .slot0_already_issued_i (ai[0]),
        .slot1_valid_i          (valid[1]),
        .slot1_rd_i             (rd[1]),
        .slot1_rs1_i            (rs1[1]),
        .slot1_rs2_i            (rs2[1]),
        .slot1_rd_we_i          (rd_we[1]),
        .slot1_csr_i            (csr[1]),
        .slot1_ctrl_flow_i      (cf[1]),
        .slot1_already_issued_i (ai[1]),
        .commit0_valid_i        (c_valid[0]),
        .commit0_id_i           (c_id[0]),
        .commit1_valid_i        (c_valid[1]),
        .commit1_id_i           (c_id[1]),
        .issue_mask_o           (issue_mask),
        .stall_o                (stall),
        .slot0_id_o             (id0),
        .slot1_id_o             (id1),
        .lock_o                 (lock)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // hard stop in case the stimulus loop stalls, counter starts at 0
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    function automatic int rand_below(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    function automatic logic chance(input int pct);
        return rand_below(100) < pct;
    endfunction

    // random entry among those the model holds, table must not be empty
    function automatic issue_pkg::commit_id_t pick_occupied();
        int cnt;
        int k;
        issue_pkg::commit_id_t id;
        cnt = 0;
        id  = '0;
        for (int e = 0; e < DEPTH; e++) begin
            if (m_valid[e]) cnt++;
        end
        k = rand_below(cnt);
        for (int e = 0; e < DEPTH; e++) begin
            if (m_valid[e]) begin
                if (k == 0) id = issue_pkg::commit_id_t'(e);
                k--;
            end
        end
        return id;
    endfunction

    task automatic clear_inputs();
        for (int s = 0; s < 2; s++) begin
            valid[s]   = 1'b0;
            rd[s]      = '0;
            rs1[s]     = '0;
            rs2[s]     = '0;
            rd_we[s]   = 1'b0;
            csr[s]     = 1'b0;
            cf[s]      = 1'b0;
            ai[s]      = 1'b0;
            c_valid[s] = 1'b0;
            c_id[s]    = '0;
        end
    endtask

    // registers 0..7 only, so hazards come often
    task automatic randomize_inputs(input int cycle);
        int commit_pct;
        commit_pct = ((cycle / 250) % 2 == 0) ? 10 : 55;  // slow phases fill the table
        for (int s = 0; s < 2; s++) begin
            valid[s] = chance(85);
            ai[s]    = chance(15);
            rd[s]    = issue_pkg::reg_addr_t'(rand_below(8));
            rs1[s]   = issue_pkg::reg_addr_t'(rand_below(8));
            rs2[s]   = issue_pkg::reg_addr_t'(rand_below(8));
            rd_we[s] = chance(70);
            csr[s]   = chance(10);
            cf[s]    = chance(10);
            c_valid[s] = (m_valid != '0) && chance(commit_pct);
            c_id[s]    = c_valid[s] ? pick_occupied() : '0;
        end
    endtask

    task automatic predict();
        issue_pkg::entry_mask_t clr;
        issue_pkg::entry_mask_t live;
        issue_pkg::commit_id_t  fid [2];
        issue_pkg::issue_mask_t m;
        logic act [2];
        logic trk [2];
        logic hz [2];
        logic dep;
        logic ser;
        int   nfree;
        clr = '0;
        for (int c = 0; c < 2; c++) begin
            if (c_valid[c]) clr[c_id[c]] = 1'b1;
        end
        live = m_valid & ~clr;  // same-cycle commit no longer blocks
        for (int s = 0; s < 2; s++) begin
            act[s] = valid[s] && !ai[s];
            trk[s] = act[s] && rd_we[s] && (rd[s] != '0);
            hz[s]  = 1'b0;
            for (int e = 0; e < DEPTH; e++) begin
                if (live[e] && act[s] && rs1[s] != '0 && rs1[s] == m_rd[e]) hz[s] = 1'b1;
                if (live[e] && act[s] && rs2[s] != '0 && rs2[s] == m_rd[e]) hz[s] = 1'b1;
                if (live[e] && trk[s] && rd[s] == m_rd[e]) hz[s] = 1'b1;
            end
        end
        dep = (trk[0] && act[1] && (rs1[1] == rd[0] || rs2[1] == rd[0]))
            || (trk[0] && trk[1] && rd[1] == rd[0])
            || (act[0] && act[1] && csr[0] && csr[1]);
        ser = act[0] && cf[0];
        nfree = 0;
        fid[0] = '0;
        fid[1] = '0;
        for (int e = 0; e < DEPTH; e++) begin
            if (!m_valid[e]) begin
                if (nfree < 2) fid[nfree] = issue_pkg::commit_id_t'(e);
                nfree++;
            end
        end
        // slot 0 waits only on its own hazard, slot 1 on everything
        m[0] = !hz[0];
        m[1] = !hz[1] && !dep && !ser;
        if (nfree == 0) m = 2'b00;
        else if (nfree == 1) m[1] = 1'b0;
        exp_mask  = m;
        exp_stall = (m != 2'b11);
        exp_lock  = (m_valid != '0);
        exp_id0   = (act[0] && m[0]) ? fid[0] : '0;
        exp_id1   = (act[1] && m[1]) ? fid[1] : '0;
        nxt_valid = live;
        nxt_rd    = m_rd;
        for (int s = 0; s < 2; s++) begin
            if (m[s] && trk[s]) begin
                nxt_valid[fid[s]] = 1'b1;  // allocation beats a commit
                nxt_rd[fid[s]]    = rd[s];
            end
        end
    endtask

    task automatic check_mask(input string name, input issue_pkg::issue_mask_t got,
                              input issue_pkg::issue_mask_t exp);
        if (got !== exp) begin
            mask_errs++;
            $display("FAILED at %0d ns: %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    task automatic check_id(input string name, input issue_pkg::commit_id_t got,
                            input issue_pkg::commit_id_t exp);
        if (got !== exp) begin
            id_errs++;
            $display("FAILED at %0d ns: %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            bit_errs++;
            $display("FAILED at %0d ns: %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    // outputs are settled at the falling edge
    task automatic check_cycle();
        @(negedge clk);
        predict();
        check_mask("issue_mask_o", issue_mask, exp_mask);
        check_bit("stall_o", stall, exp_stall);
        check_bit("lock_o", lock, exp_lock);
        check_id("slot0_id_o", id0, exp_id0);
        check_id("slot1_id_o", id1, exp_id1);
        m_valid = nxt_valid;
        m_rd    = nxt_rd;
    endtask

    initial begin
        seed      = 81141;
        mask_errs = 0;
        id_errs   = 0;
        bit_errs  = 0;
        rst_n     = 1'b0;
        m_valid   = '0;
        for (int e = 0; e < DEPTH; e++) m_rd[e] = '0;
        clear_inputs();
        repeat (5) @(posedge clk);
        #2 rst_n = 1'b1;
        check_cycle();  // idle slots on an empty table
        for (int n = 0; n < NUM_CYCLES; n++) begin
            @(posedge clk);
            #2;
            randomize_inputs(n);
            check_cycle();
        end
        $display("errors: mask %0d, id %0d, stall/lock %0d", mask_errs, id_errs, bit_errs);
        if (mask_errs + id_errs + bit_errs == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// ==== src/commit_if.sv ====
/*
 completion strobes from the two execution ports
*/
interface commit_if;

    logic                  commit0_valid;  // one-cycle strobe
    issue_pkg::commit_id_t commit0_id;
    logic                  commit1_valid;
    issue_pkg::commit_id_t commit1_id;

    modport top (
        output commit0_valid, commit0_id, commit1_valid, commit1_id
    );

    modport consumer (
        input commit0_valid, commit0_id, commit1_valid, commit1_id
    );

endinterface

// ==== src/dual_issue_ctrl.sv ====
/*
 dual-issue control top, decides which of two decoded slots issue,
 hands out commit IDs and tracks outstanding long-latency writes
*/
module dual_issue_ctrl (
    input  logic                   clk,
    input  logic                   rst_n,

    input  logic                   slot0_valid_i,
    input  issue_pkg::reg_addr_t   slot0_rd_i,
    input  issue_pkg::reg_addr_t   slot0_rs1_i,
    input  issue_pkg::reg_addr_t   slot0_rs2_i,
    input  logic                   slot0_rd_we_i,
    input  logic                   slot0_csr_i,
    input  logic                   slot0_ctrl_flow_i,
    input  logic                   slot0_already_issued_i,

    input  logic                   slot1_valid_i,
    input  issue_pkg::reg_addr_t   slot1_rd_i,
    input  issue_pkg::reg_addr_t   slot1_rs1_i,
    input  issue_pkg::reg_addr_t   slot1_rs2_i,
    input  logic                   slot1_rd_we_i,
    input  logic                   slot1_csr_i,
    input  logic                   slot1_ctrl_flow_i,
    input  logic                   slot1_already_issued_i,

    input  logic                   commit0_valid_i,
    input  issue_pkg::commit_id_t  commit0_id_i,
    input  logic                   commit1_valid_i,
    input  issue_pkg::commit_id_t  commit1_id_i,

    output issue_pkg::issue_mask_t issue_mask_o,
    output logic                   stall_o,
    output issue_pkg::commit_id_t  slot0_id_o,
    output issue_pkg::commit_id_t  slot1_id_o,
    output logic                   lock_o
);

    issue_slot_if slot0_if ();
    issue_slot_if slot1_if ();
    commit_if     commit_bus ();

    issue_pkg::entry_mask_t occupied;
    issue_pkg::entry_mask_t live;
    issue_pkg::reg_addr_t   entry_rd [issue_pkg::TABLE_DEPTH];
    issue_pkg::commit_id_t  free_id0;
    issue_pkg::commit_id_t  free_id1;
    issue_pkg::issue_mask_t issue_mask;
    logic                   one_free;
    logic                   two_free;

    assign slot0_if.valid          = slot0_valid_i;
    assign slot0_if.rd             = slot0_rd_i;
    assign slot0_if.rs1            = slot0_rs1_i;
    assign slot0_if.rs2            = slot0_rs2_i;
    assign slot0_if.rd_we          = slot0_rd_we_i;
    assign slot0_if.csr            = slot0_csr_i;
    assign slot0_if.ctrl_flow      = slot0_ctrl_flow_i;
    assign slot0_if.already_issued = slot0_already_issued_i;

    assign slot1_if.valid          = slot1_valid_i;
    assign slot1_if.rd             = slot1_rd_i;
    assign slot1_if.rs1            = slot1_rs1_i;
    assign slot1_if.rs2            = slot1_rs2_i;
    assign slot1_if.rd_we          = slot1_rd_we_i;
    assign slot1_if.csr            = slot1_csr_i;
    assign slot1_if.ctrl_flow      = slot1_ctrl_flow_i;
    assign slot1_if.already_issued = slot1_already_issued_i;

    assign commit_bus.commit0_valid = commit0_valid_i;
    assign commit_bus.commit0_id    = commit0_id_i;
    assign commit_bus.commit1_valid = commit1_valid_i;
    assign commit_bus.commit1_id    = commit1_id_i;

    pending_write_table u_table (
        .clk          (clk),
        .rst_n        (rst_n),
        .slot0        (slot0_if),
        .slot1        (slot1_if),
        .commit       (commit_bus),
        .issue_mask_i (issue_mask),
        .free_id0_i   (free_id0),
        .free_id1_i   (free_id1),
        .occupied_o   (occupied),
        .live_o       (live),
        .entry_rd_o   (entry_rd)
    );

    free_slot_picker u_picker (
        .occupied_i (occupied),
        .free_id0_o (free_id0),
        .free_id1_o (free_id1),
        .one_free_o (one_free),
        .two_free_o (two_free)
    );

    hazard_detect u_hazard (
        .slot0        (slot0_if),
        .slot1        (slot1_if),
        .live_i       (live),
        .entry_rd_i   (entry_rd),
        .one_free_i   (one_free),
        .two_free_i   (two_free),
        .issue_mask_o (issue_mask)
    );

    assign issue_mask_o = issue_mask;
    assign stall_o      = (issue_mask != 2'b11);  // decode holds both slots
    assign lock_o       = |occupied;

    // slot 1 keeps free_id1 even when slot 0 stays back
    assign slot0_id_o = (slot0_if.active && issue_mask[0]) ? free_id0 : '0;
    assign slot1_id_o = (slot1_if.active && issue_mask[1]) ? free_id1 : '0;

endmodule

// ==== src/free_slot_picker.sv ====
/*
 free entry picker, finds the two lowest free table entries
 and reports whether one or two are available
*/
module free_slot_picker (
    input  issue_pkg::entry_mask_t occupied_i,
    output issue_pkg::commit_id_t  free_id0_o,
    output issue_pkg::commit_id_t  free_id1_o,
    output logic                   one_free_o,
    output logic                   two_free_o
);

    logic found0;
    logic found1;

    // scan upward, first hole goes to slot 0, second to slot 1
    always_comb begin
        free_id0_o = '0;
        free_id1_o = '0;
        found0     = 1'b0;
        found1     = 1'b0;
        for (int i = 0; i < issue_pkg::TABLE_DEPTH; i++) begin
            if (!occupied_i[i]) begin
                if (!found0) begin
                    free_id0_o = issue_pkg::commit_id_t'(i);
                    found0     = 1'b1;
                end else if (!found1) begin
                    free_id1_o = issue_pkg::commit_id_t'(i);  // next hole above id0
                    found1     = 1'b1;
                end
            end
        end
    end

    assign one_free_o = found0;
    assign two_free_o = found1;  // implies found0

endmodule

// ==== src/hazard_detect.sv ====
/*
 hazard detector, checks both slots against live pending writes and each
 other, applies jump serialization and table capacity to the issue mask
*/
module hazard_detect (
    issue_slot_if.consumer         slot0,
    issue_slot_if.consumer         slot1,

    input  issue_pkg::entry_mask_t live_i,
    input  issue_pkg::reg_addr_t   entry_rd_i [issue_pkg::TABLE_DEPTH],
    input  logic                   one_free_i,
    input  logic                   two_free_i,

    output issue_pkg::issue_mask_t issue_mask_o
);

    logic h0;     // slot 0 blocked by a live entry
    logic h1;     // slot 1 blocked by a live entry
    logic d10;    // slot 1 depends on slot 0
    logic ser;    // slot 0 must go alone
    logic raw10;
    logic waw10;
    logic csr10;

    issue_pkg::issue_mask_t base_mask;

    // RAW on either source or WAW on the destination against one entry
    function automatic logic slot_hits(
        input logic                 active,
        input issue_pkg::reg_addr_t rs1,
        input issue_pkg::reg_addr_t rs2,
        input logic                 rd_track,
        input issue_pkg::reg_addr_t rd,
        input issue_pkg::reg_addr_t addr
    );
        logic raw;
        logic waw;
        raw = active && (((rs1 != '0) && (rs1 == addr)) || ((rs2 != '0) && (rs2 == addr)));
        waw = rd_track && (rd == addr);
        return raw || waw;
    endfunction

    always_comb begin
        h0 = 1'b0;
        h1 = 1'b0;
        for (int i = 0; i < issue_pkg::TABLE_DEPTH; i++) begin
            if (live_i[i]) begin
                h0 = h0 | slot_hits(slot0.active, slot0.rs1, slot0.rs2,
                                    slot0.rd_track, slot0.rd, entry_rd_i[i]);
                h1 = h1 | slot_hits(slot1.active, slot1.rs1, slot1.rs2,
                                    slot1.rd_track, slot1.rd, entry_rd_i[i]);
            end
        end
    end

    // slot 0 rd is nonzero whenever rd_track is set
    assign raw10 = slot0.rd_track && slot1.active &&
                   ((slot1.rs1 == slot0.rd) || (slot1.rs2 == slot0.rd));
    assign waw10 = slot0.rd_track && slot1.rd_track && (slot1.rd == slot0.rd);
    assign csr10 = slot0.active && slot1.active && slot0.csr && slot1.csr;  // csr pairs serialize
    assign d10   = raw10 || waw10 || csr10;

    assign ser   = slot0.active && slot0.ctrl_flow;

    always_comb begin
        if (h0 && ser) begin
            base_mask = 2'b00;
        end else if (h0) begin
            base_mask = (!h1 && !d10) ? 2'b10 : 2'b00;  // slot 1 may pass a stuck slot 0
        end else if (ser) begin
            base_mask = 2'b01;
        end else begin
            base_mask = (!h1 && !d10) ? 2'b11 : 2'b01;
        end
    end

    // capacity gating
    always_comb begin
        issue_mask_o = base_mask;
        if (!one_free_i) begin
            issue_mask_o = 2'b00;
        end else if (!two_free_i) begin
            issue_mask_o[1] = 1'b0;  // slot 1 always takes the second entry
        end
    end

endmodule

// ==== src/issue_pkg.sv ====
/*
 shared widths and types of the dual-issue control block
 register addresses, commit IDs, table masks and the issue mask
*/
package issue_pkg;

    localparam int REG_ADDR_W  = 5;
    localparam int COMMIT_ID_W = 3;

    // one pending-write entry per commit ID
    localparam int TABLE_DEPTH = 1 << COMMIT_ID_W;

    // x0 never takes part in a hazard
    typedef logic [REG_ADDR_W-1:0]  reg_addr_t;

    typedef logic [COMMIT_ID_W-1:0] commit_id_t;  // index into the table

    // one bit per table entry
    typedef logic [TABLE_DEPTH-1:0] entry_mask_t;

    // bit 0 issues slot 0, bit 1 issues slot 1
    typedef logic [1:0]             issue_mask_t;

endpackage

// ==== src/issue_slot_if.sv ====
/*
 one decoded instruction slot as seen by the issue stage
*/
interface issue_slot_if;

    logic                  valid;
    issue_pkg::reg_addr_t  rd;
    issue_pkg::reg_addr_t  rs1;
    issue_pkg::reg_addr_t  rs2;
    logic                  rd_we;
    logic                  csr;
    logic                  ctrl_flow;       // jump or branch
    logic                  already_issued;  // went out in an earlier cycle

    logic                  active;
    logic                  rd_track;

    // already issued slots are held by decode but no longer count
    assign active   = valid && !already_issued;
    assign rd_track = active && rd_we && (rd != '0);  // write worth tracking

    modport top (
        output valid, rd, rs1, rs2, rd_we, csr, ctrl_flow, already_issued,
        input  active, rd_track
    );

    modport consumer (
        input valid, rd, rs1, rs2, rd_we, csr, ctrl_flow, already_issued,
        input active, rd_track
    );

endinterface

// ==== src/pending_write_table.sv ====
/*
 pending write table, tracks destinations of issued long-latency writes
 until their commit strobe arrives, and exposes the live mask for hazards
*/
module pending_write_table (
    input  logic                  clk,
    input  logic                  rst_n,

    issue_slot_if.consumer        slot0,
    issue_slot_if.consumer        slot1,
    commit_if.consumer            commit,

    input  issue_pkg::issue_mask_t issue_mask_i,
    input  issue_pkg::commit_id_t  free_id0_i,
    input  issue_pkg::commit_id_t  free_id1_i,

    output issue_pkg::entry_mask_t occupied_o,
    output issue_pkg::entry_mask_t live_o,
    output issue_pkg::reg_addr_t   entry_rd_o [issue_pkg::TABLE_DEPTH]
);

    issue_pkg::entry_mask_t valid_q;
    issue_pkg::entry_mask_t valid_nxt;
    issue_pkg::reg_addr_t   rd_q [issue_pkg::TABLE_DEPTH];

    issue_pkg::entry_mask_t commit_clr;
    issue_pkg::entry_mask_t alloc_set;

    logic alloc0;
    logic alloc1;

    // only issued slots with a real destination take an entry
    assign alloc0 = issue_mask_i[0] && slot0.rd_track;
    assign alloc1 = issue_mask_i[1] && slot1.rd_track;

    always_comb begin
        commit_clr = '0;
        alloc_set  = '0;
        if (commit.commit0_valid) begin
            commit_clr[commit.commit0_id] = 1'b1;
        end
        if (commit.commit1_valid) begin
            commit_clr[commit.commit1_id] = 1'b1;
        end
        if (alloc0) begin
            alloc_set[free_id0_i] = 1'b1;
        end
        if (alloc1) begin
            alloc_set[free_id1_i] = 1'b1;
        end
    end

    // allocation wins over a commit to the same entry
    assign valid_nxt = (valid_q & ~commit_clr) | alloc_set;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= '0;
            for (int i = 0; i < issue_pkg::TABLE_DEPTH; i++) begin
                rd_q[i] <= '0;
            end
        end else begin
            valid_q <= valid_nxt;
            if (alloc0) begin
                rd_q[free_id0_i] <= slot0.rd;
            end
            if (alloc1) begin
                rd_q[free_id1_i] <= slot1.rd;  // never the same entry as slot 0
            end
        end
    end

    assign occupied_o = valid_q;

    // committing entries stop blocking in the commit cycle itself
    assign live_o     = valid_q & ~commit_clr;
    assign entry_rd_o = rd_q;

endmodule
